/* mc_bus_pkg.sv */
//**********************************************************
// mc bus fabric shared definitions
// wishbone request/response types, slave index, baud and
// sd card line types, i/o page address map
//**********************************************************
package mc_bus_pkg;

	localparam int NUM_DEV = 8; // slaves hanging on the wishbone bus

	// one master's request as seen by the fabric
	typedef struct packed {
		logic [16:0] adr; // byte address, bit 16 selects console page
		logic [15:0] dat; // write data
		logic        cyc; // bus cycle open
		logic        we;  // 1 - write, 0 - read
		logic [1:0]  sel; // byte lanes
		logic        stb; // data strobe
	} bus_req_t;

	// response returned to the owning master
	typedef struct packed {
		logic [15:0] dat; // merged read data
		logic        ack; // merged acknowledge
	} bus_resp_t;

	// slave index into strobe and ack vectors
	typedef enum logic [2:0] {
		DEV_ROM,   // monitor rom, shadow area
		DEV_DRAM,  // all dram banks
		DEV_UART1, // console uart
		DEV_UART2, // second uart
		DEV_RK,    // rk11 disk
		DEV_LPT,   // printer port
		DEV_DW,    // dw hard disk
		DEV_RX     // rx01 floppy
	} dev_e;

	typedef logic [NUM_DEV-1:0]       dev_mask_t;
	typedef logic [NUM_DEV-1:0][15:0] slave_dat_t; // one word per slave

	typedef enum logic {
		MASTER_CPU,
		MASTER_DMA // rk11 dma channel
	} master_e;

	// terminal speed index, as reported by the vt52
	typedef enum logic [2:0] {
		SPEED_1200,
		SPEED_2400,
		SPEED_4800,
		SPEED_9600,
		SPEED_19200,
		SPEED_38400,
		SPEED_57600,
		SPEED_115200
	} speed_e;

	typedef logic [31:0] baud_div_t; // uart clock divisor

	// lines one disk controller drives towards the card
	typedef struct packed {
		logic cs;
		logic mosi;
	} sd_lines_t;

	//**********************************************************
	// i/o page map, base address and ignored low bits
	//**********************************************************
	localparam logic [16:0] UART1_BASE = 17'o177560; // 177560-177566
	localparam int          UART1_W    = 3;
	localparam logic [16:0] UART2_BASE = 17'o176500; // 176500-176506
	localparam int          UART2_W    = 3;
	localparam logic [16:0] RK_BASE    = 17'o177400; // 177400-177416
	localparam int          RK_W       = 4;
	localparam logic [16:0] LPT_BASE   = 17'o177514; // 177514-177516
	localparam int          LPT_W      = 2;
	localparam logic [16:0] DW_BASE    = 17'o174000; // 174000-174036
	localparam int          DW_W       = 5;
	localparam logic [16:0] RX_BASE    = 17'o177170; // 177170-177172
	localparam int          RX_W       = 2;

endpackage

/* bus_master_switch.sv */
//**********************************************************
// wishbone master switch
// hands the bus to the cpu or to the rk11 dma channel,
// owner changes only while no bus cycle is open
//**********************************************************
`timescale 1ns/1ns

module bus_master_switch (
	input  logic                  wb_clk,
	input  logic                  rst_i,
	input  mc_bus_pkg::bus_req_t  cpu_req_i,  // cpu side
	input  mc_bus_pkg::bus_req_t  dma_bus_i,  // dma side
	input  logic                  dma_req_i,  // dma wants the bus
	input  mc_bus_pkg::bus_resp_t bus_resp_i, // merged slave response
	output mc_bus_pkg::bus_req_t  bus_req_o,  // shared bus
	output mc_bus_pkg::bus_resp_t cpu_resp_o,
	output mc_bus_pkg::bus_resp_t dma_resp_o,
	output logic                  dma_gnt_o
);
	import mc_bus_pkg::*;

	master_e owner; // current bus owner

	//**********************************************************
	// ownership, re-decided on every edge with cyc low
	//**********************************************************
	always_ff @(posedge wb_clk) begin
		if (rst_i) begin
			owner <= MASTER_CPU;
		end else if (!bus_req_o.cyc) begin
			owner <= dma_req_i ? MASTER_DMA : MASTER_CPU; // dma has the upper hand
		end
	end

	assign dma_gnt_o = (owner == MASTER_DMA);

	// request steering
	always_comb begin
		if (owner == MASTER_DMA) begin
			bus_req_o     = dma_bus_i;
			bus_req_o.sel = 2'b11; // dma always moves whole words
		end else begin
			bus_req_o = cpu_req_i;
		end
	end

	// read data goes to both, ack only to the owner
	always_comb begin
		cpu_resp_o.dat = bus_resp_i.dat;
		cpu_resp_o.ack = bus_resp_i.ack & (owner == MASTER_CPU);
		dma_resp_o.dat = bus_resp_i.dat;
		dma_resp_o.ack = bus_resp_i.ack & (owner == MASTER_DMA);
	end

	// an open cycle freezes the owner until cyc drops
	a_owner_frozen: assert property (@(posedge wb_clk) disable iff (rst_i)
		bus_req_o.cyc |=> $stable(owner));

endmodule

/* io_page_select.sv */
//**********************************************************
// wishbone address decoder
// one strobe per slave, ack OR and read data merge,
// page 7 goes to dram in console mode (adr bit 16)
//**********************************************************
`timescale 1ns/1ns

module io_page_select (
	input  mc_bus_pkg::bus_req_t   bus_req_i,   // shared bus from the switch
	input  mc_bus_pkg::dev_mask_t  slave_ack_i, // per slave ack
	input  mc_bus_pkg::slave_dat_t slave_dat_i, // per slave read data
	output mc_bus_pkg::dev_mask_t  slave_stb_o, // per slave strobe
	output mc_bus_pkg::bus_resp_t  bus_resp_o   // merged response
);
	import mc_bus_pkg::*;

	logic        bus_sel; // cycle and strobe both up
	logic [16:0] adr;
	logic [15:0] rd_dat;  // merged read data

	// true when the bits above the ignored field match the base
	function automatic logic io_hit(input logic [16:0] a, input logic [16:0] base,
		input int w);
		return (a >> w) == (base >> w);
	endfunction

	assign bus_sel = bus_req_i.cyc & bus_req_i.stb;
	assign adr     = bus_req_i.adr;

	//**********************************************************
	// address decode
	//**********************************************************
	always_comb begin
		slave_stb_o = '0;
		// monitor rom, 140000 of the console page
		slave_stb_o[DEV_ROM]   = bus_sel & (adr[16:13] == 4'b1110);
		// user mode 000000-157776, console mode 160000-177776
		slave_stb_o[DEV_DRAM]  = bus_sel & ((adr[15:13] != 3'b111) ^ adr[16]);
		// i/o page
		slave_stb_o[DEV_UART1] = bus_sel & io_hit(adr, UART1_BASE, UART1_W);
		slave_stb_o[DEV_UART2] = bus_sel & io_hit(adr, UART2_BASE, UART2_W);
		slave_stb_o[DEV_RK]    = bus_sel & io_hit(adr, RK_BASE, RK_W);
		slave_stb_o[DEV_LPT]   = bus_sel & io_hit(adr, LPT_BASE, LPT_W);
		slave_stb_o[DEV_DW]    = bus_sel & io_hit(adr, DW_BASE, DW_W);
		slave_stb_o[DEV_RX]    = bus_sel & io_hit(adr, RX_BASE, RX_W);
		// map regions are disjoint for any address
		a_stb_onehot: assert ($onehot0(slave_stb_o))
			else $error("overlapping slave strobes %b", slave_stb_o);
	end

	//**********************************************************
	// response merge
	//**********************************************************
	always_comb begin
		rd_dat = '0;
		for (int i = 0; i < NUM_DEV; i++) begin
			if (slave_stb_o[i]) begin
				rd_dat |= slave_dat_i[i]; // unselected slaves contribute zero
			end
		end
	end

	assign bus_resp_o.dat = rd_dat;
	assign bus_resp_o.ack = |slave_ack_i; // slaves only ack their own strobe

endmodule

/* sdcard_arbiter.sv */
//**********************************************************
// sd card access arbiter
// fixed priority grant among the disk controllers,
// card cs and mosi switched to the owner
//**********************************************************
`timescale 1ns/1ns

module sdcard_arbiter #(
	parameter int NUM_SD_PORTS = 3 // rk, dw, dx
) (
	input  logic                                    wb_clk,
	input  logic                                    rst_i,
	input  logic [NUM_SD_PORTS-1:0]                 sd_req_i,  // held for whole access
	input  mc_bus_pkg::sd_lines_t [NUM_SD_PORTS-1:0] sd_port_i, // lines per controller
	output logic [NUM_SD_PORTS-1:0]                 sd_gnt_o,
	output mc_bus_pkg::sd_lines_t                   sd_o       // towards the card
);
	import mc_bus_pkg::*;

	logic [NUM_SD_PORTS-1:0] first_req; // lowest requester only
	logic                    gnt_busy;
	logic                    owner_done; // owner dropped its request

	assign first_req  = sd_req_i & (~sd_req_i + 1'b1); // isolate lowest set bit
	assign gnt_busy   = |sd_gnt_o;
	assign owner_done = ~|(sd_gnt_o & sd_req_i);

	//**********************************************************
	// grant register
	//**********************************************************
	always_ff @(posedge wb_clk) begin
		if (rst_i) begin
			sd_gnt_o <= '0;
		end else if (!gnt_busy) begin
			sd_gnt_o <= first_req; // idle, pick a requester
		end else if (owner_done) begin
			sd_gnt_o <= '0; // release, one idle cycle before next owner
		end
	end

	// line mux, rk keeps the card when nobody owns it
	always_comb begin
		sd_o = sd_port_i[0];
		for (int i = 1; i < NUM_SD_PORTS; i++) begin
			if (sd_gnt_o[i]) begin
				sd_o = sd_port_i[i];
			end
		end
	end

	a_gnt_onehot: assert property (@(posedge wb_clk) disable iff (rst_i)
		$onehot0(sd_gnt_o));

endmodule

/* console_router.sv */
//**********************************************************
// console router
// swaps uart lines between vt52 terminal and external port,
// terminal side uart follows the terminal speed
//**********************************************************
`timescale 1ns/1ns

module console_router #(
	parameter mc_bus_pkg::baud_div_t AUX_BAUD_DIV = 32'd23 // external port divisor
) (
	input  logic                  console_sel_i, // 0 - uart1 on terminal
	input  mc_bus_pkg::speed_e    speed_i,       // terminal speed index
	input  logic                  terminal_tx_i,
	input  logic                  aux_rxd_i,
	input  logic                  uart1_txd_i,
	input  logic                  uart2_txd_i,
	output logic                  terminal_rx_o,
	output logic                  aux_txd_o,
	output logic                  uart1_rxd_o,
	output logic                  uart2_rxd_o,
	output mc_bus_pkg::baud_div_t uart1_div_o,
	output mc_bus_pkg::baud_div_t uart2_div_o
);
	import mc_bus_pkg::*;

	baud_div_t term_div; // divisor matching the terminal

	// divisors off the 921600 uart reference
	always_comb begin
		unique case (speed_i)
			SPEED_1200:   term_div = 32'd767;
			SPEED_2400:   term_div = 32'd383;
			SPEED_4800:   term_div = 32'd191;
			SPEED_9600:   term_div = 32'd95;
			SPEED_19200:  term_div = 32'd47;
			SPEED_38400:  term_div = 32'd23;
			SPEED_57600:  term_div = 32'd15;
			SPEED_115200: term_div = 32'd7;
		endcase
	end

	// serial line swap
	assign terminal_rx_o = console_sel_i ? uart2_txd_i : uart1_txd_i;
	assign aux_txd_o     = console_sel_i ? uart1_txd_i : uart2_txd_i;
	assign uart1_rxd_o   = console_sel_i ? aux_rxd_i : terminal_tx_i;
	assign uart2_rxd_o   = console_sel_i ? terminal_tx_i : aux_rxd_i;

	assign uart1_div_o = console_sel_i ? AUX_BAUD_DIV : term_div;
	assign uart2_div_o = console_sel_i ? term_div : AUX_BAUD_DIV;

endmodule

/* mc_bus_fabric.sv */
//**********************************************************
// mc1201.02 bus fabric top
// master switch feeding the address decoder, with sd card
// arbiter and console router alongside
//**********************************************************
`timescale 1ns/1ns

module mc_bus_fabric #(
	parameter int                    NUM_SD_PORTS = 3,
	parameter mc_bus_pkg::baud_div_t AUX_BAUD_DIV = 32'(921600 / 38400 - 1)
) (
	input  logic                                    wb_clk,
	input  logic                                    rst_i,
	// bus masters
	input  mc_bus_pkg::bus_req_t                    cpu_req_i,
	output mc_bus_pkg::bus_resp_t                   cpu_resp_o,
	input  logic                                    dma_req_i,
	input  mc_bus_pkg::bus_req_t                    dma_bus_i,
	output logic                                    dma_gnt_o,
	output mc_bus_pkg::bus_resp_t                   dma_resp_o,
	// slaves
	output mc_bus_pkg::dev_mask_t                   slave_stb_o,
	input  mc_bus_pkg::dev_mask_t                   slave_ack_i,
	input  mc_bus_pkg::slave_dat_t                  slave_dat_i,
	// sd card
	input  logic [NUM_SD_PORTS-1:0]                 sd_req_i,
	input  mc_bus_pkg::sd_lines_t [NUM_SD_PORTS-1:0] sd_port_i,
	output logic [NUM_SD_PORTS-1:0]                 sd_gnt_o,
	output mc_bus_pkg::sd_lines_t                   sd_o,
	// console
	input  logic                                    console_sel_i,
	input  mc_bus_pkg::speed_e                      speed_i,
	input  logic                                    terminal_tx_i,
	input  logic                                    aux_rxd_i,
	input  logic                                    uart1_txd_i,
	input  logic                                    uart2_txd_i,
	output logic                                    terminal_rx_o,
	output logic                                    aux_txd_o,
	output logic                                    uart1_rxd_o,
	output logic                                    uart2_rxd_o,
	output mc_bus_pkg::baud_div_t                   uart1_div_o,
	output mc_bus_pkg::baud_div_t                   uart2_div_o
);
	import mc_bus_pkg::*;

	bus_req_t  bus_req;  // shared wishbone request
	bus_resp_t bus_resp; // merged slave response

	bus_master_switch u_bus_master_switch (
		.wb_clk, .rst_i, .cpu_req_i, .dma_bus_i, .dma_req_i,
		.bus_resp_i(bus_resp), .bus_req_o(bus_req),
		.cpu_resp_o, .dma_resp_o, .dma_gnt_o
	);

	io_page_select u_io_page_select (
		.bus_req_i(bus_req), .slave_ack_i, .slave_dat_i,
		.slave_stb_o, .bus_resp_o(bus_resp)
	);

	sdcard_arbiter #(.NUM_SD_PORTS(NUM_SD_PORTS)) u_sdcard_arbiter (
		.wb_clk, .rst_i, .sd_req_i, .sd_port_i, .sd_gnt_o, .sd_o
	);

	console_router #(.AUX_BAUD_DIV(AUX_BAUD_DIV)) u_console_router (
		.console_sel_i, .speed_i, .terminal_tx_i, .aux_rxd_i,
		.uart1_txd_i, .uart2_txd_i, .terminal_rx_o, .aux_txd_o,
		.uart1_rxd_o, .uart2_rxd_o, .uart1_div_o, .uart2_div_o
	);

endmodule

/* tb_mc_bus_fabric.sv */
//**********************************************************
// mc bus fabric testbench
// directed tests of decode, merge, bus ownership,
// sd card arbitration and console routing
//**********************************************************
`timescale 1ns/1ns

module tb_mc_bus_fabric;
	import mc_bus_pkg::*;

	localparam baud_div_t AUX_DIV = 32'd11; // external port at 76800
	// window base and decode width per slave, dram entry is the start of user memory
	localparam logic [16:0] DEV_ADR [NUM_DEV] = '{17'o340000, 17'o0, UART1_BASE,
		UART2_BASE, RK_BASE, LPT_BASE, DW_BASE, RX_BASE};
	localparam int DEV_W [NUM_DEV] = '{13, 0, UART1_W, UART2_W, RK_W, LPT_W, DW_W, RX_W};
	localparam baud_div_t TERM_DIV [8] = '{767, 383, 191, 95, 47, 23, 15, 7}; // 1200 upwards

	logic            wb_clk;
	logic            rst_i;
	logic            dma_req_i;
	logic            dma_gnt_o;
	logic            console_sel_i;
	bus_req_t        cpu_req_i;
	bus_req_t        dma_bus_i;
	bus_resp_t       cpu_resp_o;
	bus_resp_t       dma_resp_o;
	dev_mask_t       slave_stb_o;
	dev_mask_t       slave_ack_i;
	slave_dat_t      slave_dat_i;
	logic [2:0]      sd_req_i;
	logic [2:0]      sd_gnt_o;
	sd_lines_t [2:0] sd_port_i; // rk, dw, dx
	sd_lines_t       sd_o;
	speed_e          speed_i;
	logic            terminal_tx_i, aux_rxd_i, uart1_txd_i, uart2_txd_i;
	logic            terminal_rx_o, aux_txd_o, uart1_rxd_o, uart2_rxd_o;
	baud_div_t       uart1_div_o, uart2_div_o;

	mc_bus_fabric #(.NUM_SD_PORTS(3), .AUX_BAUD_DIV(AUX_DIV)) u_mc_bus_fabric (.*);

	initial begin
		wb_clk = 1'b0;
		forever #50 wb_clk = ~wb_clk; // 10 MHz
	end

	// tests take about 200 cycles, 2000 leaves a wide margin
	initial begin
		repeat (2000) @(posedge wb_clk);
		$display("Watchdog timeout: the tests did not finish within 2000 clock cycles");
		abort_run();
	end

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	//**********************************************************
	// compare tasks
	//**********************************************************
	task automatic check_mask(input dev_mask_t got, input dev_mask_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_resp(input bus_resp_t got, input bus_resp_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_lines(input sd_lines_t got, input sd_lines_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_div(input baud_div_t got, input baud_div_t exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			abort_run();
		end
	endtask

	// grants, byte lanes and serial levels
	task automatic check_level(input logic [3:0] got, input logic [3:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	//**********************************************************
	// helpers
	//**********************************************************
	task automatic step();
		@(posedge wb_clk);
		#10; // drive just after the edge
	endtask

	function automatic bus_req_t read_req(input logic [16:0] a);
		return '{adr: a, dat: 16'h0, cyc: 1'b1, we: 1'b0, sel: 2'b11, stb: 1'b1};
	endfunction

	// strobes from the address map, each window taken as a byte range
	function automatic dev_mask_t expect_mask(input logic [16:0] a);
		dev_mask_t m;
		for (int d = 0; d < NUM_DEV; d++) begin
			m[d] = 17'(a - DEV_ADR[d]) < (17'd1 << DEV_W[d]); // wraps high below base
		end
		m[DEV_DRAM] = a[16] ? (a[15:0] >= 16'o160000) : (a[15:0] < 16'o160000);
		return m;
	endfunction

	task automatic probe(input logic [16:0] a, input logic [1:0] cyc_stb);
		step();
		cpu_req_i = read_req(a);
		{cpu_req_i.cyc, cpu_req_i.stb} = cyc_stb;
		#30;
		check_mask(slave_stb_o, &cyc_stb ? expect_mask(a) : '0,
			$sformatf("strobes for %o", a));
	endtask

	//**********************************************************
	// directed tests
	//**********************************************************
	task automatic test_decode();
		for (int d = 0; d < NUM_DEV; d++) begin
			for (int k = 0; k < 4; k++) begin
				probe(DEV_ADR[d] + 17'($urandom % (1 << DEV_W[d])), 2'b11); // inside window
			end
		end
		for (int k = 0; k < 16; k++) begin
			probe(17'($urandom % 'o160000), 2'b11);               // user dram
			probe(17'o200000 | 17'($urandom % 'o160000), 2'b11);  // same, bit 16 set
			probe(17'o160000 | 17'($urandom % 'o20000), 2'b11);   // page 7, i/o
			probe(17'o360000 | 17'($urandom % 'o20000), 2'b11);   // page 7 in console mode
			probe(17'($urandom), 2'($urandom));                   // anywhere, cyc and stb too
		end
	endtask

	task automatic test_merge();
		bus_resp_t exp;
		for (int d = 0; d < NUM_DEV; d++) begin
			for (int ack = 0; ack < 2; ack++) begin
				step();
				for (int i = 0; i < NUM_DEV; i++) begin
					slave_dat_i[i] = 16'($urandom);
				end
				cpu_req_i = read_req(DEV_ADR[d]);
				slave_ack_i = dev_mask_t'(ack) << d; // only the selected slave answers
				#30;
				exp.dat = slave_dat_i[d];
				exp.ack = 1'(ack);
				check_mask(slave_stb_o, dev_mask_t'(1) << d, "merge strobe");
				check_resp(cpu_resp_o, exp, "cpu response");
			end
		end
		slave_ack_i = '0;
	endtask

	task automatic test_ownership();
		bus_resp_t exp;
		check_level(4'(dma_gnt_o), 4'b0, "dma grant after reset");
		step();
		cpu_req_i = read_req(UART1_BASE); // uart1 holds its ack back
		dma_req_i = 1'b1;
		dma_bus_i = '{adr: RK_BASE, dat: 16'h5a5a, cyc: 1'b1, we: 1'b1, sel: 2'b01, stb: 1'b1};
		repeat (3) begin
			#30;
			check_level(4'(dma_gnt_o), 4'b0, "dma grant during cpu cycle");
			step();
		end
		cpu_req_i = '0; // cpu cycle ends
		#30;
		check_level(4'(dma_gnt_o), 4'b0, "dma grant before deciding edge");
		step();
		slave_ack_i[DEV_RK] = 1'b1;
		slave_dat_i[DEV_RK] = 16'($urandom);
		#30;
		exp.dat = slave_dat_i[DEV_RK];
		exp.ack = 1'b1;
		check_level(4'(dma_gnt_o), 4'b1, "dma grant after cpu cycle");
		check_mask(slave_stb_o, dev_mask_t'(1) << DEV_RK, "dma strobe");
		check_resp(dma_resp_o, exp, "dma response");
		check_level(4'(cpu_resp_o.ack), 4'b0, "cpu ack under dma");
		check_level(4'(u_mc_bus_fabric.bus_req.sel), 4'b0011, "bus sel under dma");
		step();
		dma_bus_i = '0;
		dma_req_i = 1'b0;
		slave_ack_i = '0;
		step();
		#30;
		check_level(4'(dma_gnt_o), 4'b0, "dma grant returned");
	endtask

	task automatic test_sd();
		sd_port_i = 6'b10_01_11; // dx, dw, rk lines all distinct
		step();
		#30;
		check_level(4'(sd_gnt_o), 4'b0, "sd grant idle");
		check_lines(sd_o, sd_port_i[0], "sd lines idle");
		step();
		sd_req_i = 3'b110; // dw and dx together
		#30;
		check_level(4'(sd_gnt_o), 4'b0, "sd grant before edge");
		step();
		#30;
		check_level(4'(sd_gnt_o), 4'b0010, "sd grant to dw");
		check_lines(sd_o, sd_port_i[1], "sd lines of dw");
		step();
		sd_req_i = 3'b100; // dw done
		#30;
		check_level(4'(sd_gnt_o), 4'b0010, "sd grant held by dw");
		step();
		#30;
		check_level(4'(sd_gnt_o), 4'b0, "sd idle gap");
		check_lines(sd_o, sd_port_i[0], "sd lines in gap");
		step();
		#30;
		check_level(4'(sd_gnt_o), 4'b0100, "sd grant to dx");
		check_lines(sd_o, sd_port_i[2], "sd lines of dx");
		step();
		sd_req_i = '0;
	endtask

	task automatic test_console();
		logic [3:0] tx;  // terminal tx, aux rx, uart1 tx, uart2 tx
		logic [3:0] exp; // terminal rx, aux tx, uart1 rx, uart2 rx
		for (int sel = 0; sel < 2; sel++) begin
			for (int s = 0; s < 8; s++) begin
				step();
				tx = 4'($urandom);
				{terminal_tx_i, aux_rxd_i, uart1_txd_i, uart2_txd_i} = tx;
				console_sel_i = 1'(sel);
				speed_i = speed_e'(s);
				#30;
				exp = sel ? {tx[0], tx[1], tx[2], tx[3]} : {tx[1], tx[0], tx[3], tx[2]};
				check_level({terminal_rx_o, aux_txd_o, uart1_rxd_o, uart2_rxd_o}, exp,
					"uart lines");
				check_div(uart1_div_o, sel ? AUX_DIV : TERM_DIV[s], "uart1 divisor");
				check_div(uart2_div_o, sel ? TERM_DIV[s] : AUX_DIV, "uart2 divisor");
			end
		end
	endtask

	initial begin
		void'($urandom(32'hb862ee7a));
		rst_i = 1'b1;
		cpu_req_i = '0;
		dma_bus_i = '0;
		dma_req_i = 1'b0;
		slave_ack_i = '0;
		slave_dat_i = '0;
		sd_req_i = '0;
		sd_port_i = '0;
		console_sel_i = 1'b0;
		speed_i = SPEED_9600;
		{terminal_tx_i, aux_rxd_i, uart1_txd_i, uart2_txd_i} = 4'hf; // idle lines high
		repeat (8) @(posedge wb_clk);
		#10;
		rst_i = 1'b0;
		test_ownership(); // checks the reset owner first
		test_decode();
		test_merge();
		test_sd();
		test_console();
		$display("Test passed");
		$finish;
	end

endmodule

/* sources.f */
mc_bus_pkg.sv
bus_master_switch.sv
io_page_select.sv
sdcard_arbiter.sv
console_router.sv
mc_bus_fabric.sv
tb_mc_bus_fabric.sv

/* Makefile */
# Verilator flow for the mc bus fabric testbench

TOP = tb_mc_bus_fabric

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
